// File: Makefile
# Verilator build and run of the issue stage testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run tb_issue and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module tb_issue -f list.f -Mdir obj_dir
	./obj_dir/Vtb_issue | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/int_regfile.sv
// integer register file, two combinational read ports, one write per
// commit port, x0 reads as zero
module int_regfile (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,
    input  logic [1:0][issue_pkg::reg_addr_bits-1:0]            raddr_i,
    input  issue_pkg::commit_port_t [issue_pkg::nr_commit_ports-1:0] commit_i,
    output logic [1:0][issue_pkg::xlen-1:0]                     rdata_o
);
    import issue_pkg::*;

    logic [nr_regs-1:0][xlen-1:0] regs_q;

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    // ports are walked in order so the higher index wins on a shared
    // address, x0 is never written
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            for (int unsigned p = 0; p < nr_commit_ports; p++) begin
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    // stored contents only, a same-cycle commit is seen next cycle
    always_comb begin
        for (int unsigned r = 0; r < 2; r++) begin
            if (raddr_i[r] == '0) begin
                // hard-wired zero register
                rdata_o[r] = '0;
            end else begin
                rdata_o[r] = regs_q[raddr_i[r]];
            end
        end
    end

endmodule

// File: design/issue_gate.sv
// issue acknowledge, unit busy select, WAW check, exception and no-unit
// bypass and the multiply ordering rule
module issue_gate (
    input  issue_pkg::issue_entry_t                              issue_instr_i,
    input  logic                                                 issue_instr_valid_i,
    input  logic                                                 stall_i,
    input  issue_pkg::fu_t [issue_pkg::nr_regs-1:0]              rd_clobber_i,
    input  issue_pkg::commit_port_t [issue_pkg::nr_commit_ports-1:0] commit_i,
    input  logic                                                 flu_ready_i,
    input  logic                                                 lsu_ready_i,
    input  logic                                                 mult_valid_i,
    output logic                                                 issue_ack_o
);
    import issue_pkg::*;

    logic fu_busy;
    logic rd_free;
    logic rd_committing;

    // ------------------------------------------------------------------
    // busy of the target unit
    // ------------------------------------------------------------------
    always_comb begin
        case (issue_instr_i.fu)
            fu_alu, fu_ctrl_flow, fu_csr, fu_mult: fu_busy = !flu_ready_i;
            fu_load, fu_store:                     fu_busy = !lsu_ready_i;
            default:                               fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // WAW check
    // ------------------------------------------------------------------
    assign rd_free = rd_clobber_i[issue_instr_i.rd] == fu_none;

    // pending write of rd retires this cycle, so the slot frees up
    always_comb begin
        rd_committing = 1'b0;
        for (int unsigned p = 0; p < nr_commit_ports; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_committing = 1'b1;
            end
        end
    end

    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall_i && !fu_busy && (rd_free || rd_committing)) begin
                issue_ack_o = 1'b1;
            end
            // excepted entries and unit-less entries just drain
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == fu_none)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a multiply in flight owns the fixed latency result bus
        if (mult_valid_i && (issue_instr_i.fu != fu_mult)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

// File: design/issue_pkg.sv
// shared widths, unit and operator encodings, and the structs passed
// between the issue stage blocks
package issue_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int unsigned xlen            = 32;
    localparam int unsigned reg_addr_bits   = 5;
    localparam int unsigned nr_regs         = 32;
    localparam int unsigned nr_commit_ports = 2;
    localparam int unsigned trans_id_bits   = 3;

    // pending writer in the clobber list, or target unit of an entry
    typedef enum logic [2:0] {
        fu_none, fu_alu, fu_ctrl_flow, fu_load, fu_store, fu_mult, fu_csr
    } fu_t;

    // operator code, carried through untouched to the unit
    typedef enum logic [3:0] {
        op_add, op_sub, op_xor, op_or, op_and, op_sll, op_srl, op_sra,
        op_slt, op_sltu, op_beq, op_bne, op_lw, op_sw, op_mul, op_csrrw
    } fu_op_t;

    // ------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------
    // entry handed over from the scoreboard
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        logic [reg_addr_bits-1:0] rs1;
        logic [reg_addr_bits-1:0] rs2;
        logic [reg_addr_bits-1:0] rd;
        // immediate lives here until the unit writes its result
        logic [xlen-1:0]          result;
        logic [xlen-1:0]          pc;
        logic [trans_id_bits-1:0] trans_id;
        logic                     use_imm;
        logic                     use_pc;
        logic                     use_zimm;
        logic                     ex_valid;
    } issue_entry_t;

    // bundle presented to the functional units
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        logic [xlen-1:0]          operand_a;
        logic [xlen-1:0]          operand_b;
        logic [xlen-1:0]          imm;
        logic [trans_id_bits-1:0] trans_id;
    } fu_data_t;

    // one register file write from commit
    typedef struct packed {
        logic [reg_addr_bits-1:0] waddr;
        logic [xlen-1:0]          wdata;
        logic                     we;
    } commit_port_t;

    // operands after the forwarding and immediate muxes
    typedef struct packed {
        logic [xlen-1:0] operand_a;
        logic [xlen-1:0] operand_b;
        logic [xlen-1:0] imm;
    } operand_set_t;

endpackage

// File: design/issue_read_operands.sv
// issue and operand read stage top, hazard check, operand mux, issue
// gate, register file and issue register
module issue_read_operands (
    input  logic                                                 clk_i,
    input  logic                                                 rst_ni,
    input  logic                                                 flush_i,
    // entry from the scoreboard
    input  issue_pkg::issue_entry_t                              issue_instr_i,
    input  logic                                                 issue_instr_valid_i,
    output logic                                                 issue_ack_o,
    // scoreboard operand lookup
    output logic [issue_pkg::reg_addr_bits-1:0]                  rs1_o,
    input  logic [issue_pkg::xlen-1:0]                           rs1_i,
    input  logic                                                 rs1_valid_i,
    output logic [issue_pkg::reg_addr_bits-1:0]                  rs2_o,
    input  logic [issue_pkg::xlen-1:0]                           rs2_i,
    input  logic                                                 rs2_valid_i,
    input  issue_pkg::fu_t [issue_pkg::nr_regs-1:0]              rd_clobber_i,
    input  issue_pkg::commit_port_t [issue_pkg::nr_commit_ports-1:0] commit_i,
    // units
    input  logic                                                 flu_ready_i,
    input  logic                                                 lsu_ready_i,
    output issue_pkg::fu_data_t                                  fu_data_o,
    output logic                                                 alu_valid_o,
    output logic                                                 branch_valid_o,
    output logic                                                 lsu_valid_o,
    output logic                                                 mult_valid_o,
    output logic                                                 csr_valid_o
);
    import issue_pkg::*;

    logic                          forward_rs1;
    logic                          forward_rs2;
    logic                          stall;
    logic [1:0][reg_addr_bits-1:0] raddr;
    logic [1:0][xlen-1:0]          rdata;
    operand_set_t                  operands;

    // scoreboard is polled with the raw source fields
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;
    assign raddr = {issue_instr_i.rs2, issue_instr_i.rs1};

    int_regfile u_regfile (
        .clk_i, .rst_ni, .raddr_i(raddr), .commit_i, .rdata_o(rdata)
    );

    operand_hazard u_hazard (
        .issue_instr_i, .rd_clobber_i, .rs1_valid_i, .rs2_valid_i,
        .forward_rs1_o(forward_rs1), .forward_rs2_o(forward_rs2), .stall_o(stall)
    );

    operand_select u_select (
        .issue_instr_i, .rdata_i(rdata), .rs1_i, .rs2_i,
        .forward_rs1_i(forward_rs1), .forward_rs2_i(forward_rs2), .operands_o(operands)
    );

    issue_gate u_gate (
        .issue_instr_i, .issue_instr_valid_i, .stall_i(stall), .rd_clobber_i, .commit_i,
        .flu_ready_i, .lsu_ready_i, .mult_valid_i(mult_valid_o), .issue_ack_o
    );

    issue_register u_issue_reg (
        .clk_i, .rst_ni, .flush_i, .issue_instr_i, .issue_instr_valid_i,
        .issue_ack_i(issue_ack_o), .operands_i(operands), .fu_data_o,
        .alu_valid_o, .branch_valid_o, .lsu_valid_o, .mult_valid_o, .csr_valid_o
    );

endmodule

// File: design/issue_register.sv
// issue boundary registers holding the unit bundle and the one-hot
// registered unit valid strobes
module issue_register (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  issue_pkg::issue_entry_t issue_instr_i,
    input  logic                    issue_instr_valid_i,
    input  logic                    issue_ack_i,
    input  issue_pkg::operand_set_t operands_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    lsu_valid_o,
    output logic                    mult_valid_o,
    output logic                    csr_valid_o
);
    import issue_pkg::*;

    logic dispatch;

    // a real issue, excepted entries get no strobe
    assign dispatch = issue_instr_valid_i && issue_ack_i && !issue_instr_i.ex_valid;

    // ------------------------------------------------------------------
    // bundle register, loads every cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '{fu: fu_none, op: op_add, default: '0};
        end else begin
            fu_data_o.fu        <= issue_instr_i.fu;
            fu_data_o.op        <= issue_instr_i.op;
            fu_data_o.operand_a <= operands_i.operand_a;
            fu_data_o.operand_b <= operands_i.operand_b;
            fu_data_o.imm       <= operands_i.imm;
            fu_data_o.trans_id  <= issue_instr_i.trans_id;
        end
    end

    // ------------------------------------------------------------------
    // unit strobes
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o} <= '0;
        end else begin
            // single cycle pulse unless a new issue follows
            {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o} <= '0;
            if (dispatch) begin
                case (issue_instr_i.fu)
                    fu_alu:            alu_valid_o    <= 1'b1;
                    fu_ctrl_flow:      branch_valid_o <= 1'b1;
                    fu_load, fu_store: lsu_valid_o    <= 1'b1;
                    fu_mult:           mult_valid_o   <= 1'b1;
                    fu_csr:            csr_valid_o    <= 1'b1;
                    default: ;
                endcase
            end
            // flush wins, units must not start on squashed work
            if (flush_i) begin
                {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o} <= '0;
            end
        end
    end

endmodule

// File: design/operand_hazard.sv
// source operand hazard check against the clobber list, picks
// forwarding per source or stalls the entry
module operand_hazard (
    input  issue_pkg::issue_entry_t                    issue_instr_i,
    input  issue_pkg::fu_t [issue_pkg::nr_regs-1:0]    rd_clobber_i,
    input  logic                                       rs1_valid_i,
    input  logic                                       rs2_valid_i,
    output logic                                       forward_rs1_o,
    output logic                                       forward_rs2_o,
    output logic                                       stall_o
);
    import issue_pkg::*;

    fu_t  rs1_writer;
    fu_t  rs2_writer;
    logic rs1_clobbered;
    logic rs2_clobbered;

    // pending writer of each source
    assign rs1_writer = rd_clobber_i[issue_instr_i.rs1];
    assign rs2_writer = rd_clobber_i[issue_instr_i.rs2];

    // zimm carries a constant in the rs1 field, nothing to wait on
    assign rs1_clobbered = !issue_instr_i.use_zimm && (rs1_writer != fu_none);
    assign rs2_clobbered = rs2_writer != fu_none;

    // ------------------------------------------------------------------
    // forward or stall
    // ------------------------------------------------------------------
    always_comb begin
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        stall_o       = 1'b0;
        if (rs1_clobbered) begin
            // csr results only come back through the register file
            if (rs1_valid_i && (rs1_writer != fu_csr)) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end
        if (rs2_clobbered) begin
            if (rs2_valid_i && (rs2_writer != fu_csr)) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end
    end

endmodule

// File: design/operand_select.sv
// operand a, operand b and immediate selection for the issue bundle
module operand_select (
    input  issue_pkg::issue_entry_t         issue_instr_i,
    input  logic [1:0][issue_pkg::xlen-1:0] rdata_i,
    input  logic [issue_pkg::xlen-1:0]      rs1_i,
    input  logic [issue_pkg::xlen-1:0]      rs2_i,
    input  logic                            forward_rs1_i,
    input  logic                            forward_rs2_i,
    output issue_pkg::operand_set_t         operands_o
);
    import issue_pkg::*;

    logic imm_as_b;

    // stores and branches keep rs2 in operand b, the immediate goes in imm
    assign imm_as_b = issue_instr_i.use_imm && (issue_instr_i.fu != fu_store)
                      && (issue_instr_i.fu != fu_ctrl_flow);

    // later assignments take priority
    always_comb begin
        // register file by default
        operands_o.operand_a = rdata_i[0];
        operands_o.operand_b = rdata_i[1];
        // scoreboard value if the writer already has it
        if (forward_rs1_i) begin
            operands_o.operand_a = rs1_i;
        end
        if (forward_rs2_i) begin
            operands_o.operand_b = rs2_i;
        end
        // auipc, jal style pc operand
        if (issue_instr_i.use_pc) begin
            operands_o.operand_a = issue_instr_i.pc;
        end
        // csr immediate, zero extended rs1 field
        if (issue_instr_i.use_zimm) begin
            operands_o.operand_a = {{(xlen - reg_addr_bits){1'b0}}, issue_instr_i.rs1};
        end
        if (imm_as_b) begin
            operands_o.operand_b = issue_instr_i.result;
        end
        operands_o.imm = issue_instr_i.result;
    end

endmodule

// File: list.f
design/issue_pkg.sv
design/int_regfile.sv
design/operand_hazard.sv
design/operand_select.sv
design/issue_gate.sv
design/issue_register.sv
design/issue_read_operands.sv
tests/tb_issue.sv

// File: tests/tb_issue.sv
// directed testbench for the issue and operand read stage, with clock,
// reset, watchdog, register model, check task and one task per test
module tb_issue;
    import issue_pkg::*;

    localparam int clk_period      = 8;
    localparam int nr_tests        = 5;
    localparam int cycles_per_test = 40;

    logic clk_i;
    logic rst_ni;
    logic flush_i;
    issue_entry_t issue_instr;
    logic issue_valid;
    logic issue_ack;
    logic [reg_addr_bits-1:0] rs1_o;
    logic [reg_addr_bits-1:0] rs2_o;
    logic [xlen-1:0] rs1_i;
    logic [xlen-1:0] rs2_i;
    logic rs1_valid;
    logic rs2_valid;
    fu_t [nr_regs-1:0] rd_clobber;
    commit_port_t [nr_commit_ports-1:0] commit;
    logic flu_ready;
    logic lsu_ready;
    fu_data_t fu_data;
    logic alu_valid;
    logic branch_valid;
    logic lsu_valid;
    logic mult_valid;
    logic csr_valid;
    logic [4:0] strobes;

    // register contents as the commit rules predict them
    logic [xlen-1:0] model [nr_regs];
    integer seed = 69;
    int errors = 0;
    int checks = 0;
    string test_name = "reset";

    assign strobes = {alu_valid, branch_valid, lsu_valid, mult_valid, csr_valid};

    issue_read_operands dut0 (
        .clk_i, .rst_ni, .flush_i,
        .issue_instr_i(issue_instr), .issue_instr_valid_i(issue_valid), .issue_ack_o(issue_ack),
        .rs1_o, .rs1_i, .rs1_valid_i(rs1_valid), .rs2_o, .rs2_i, .rs2_valid_i(rs2_valid),
        .rd_clobber_i(rd_clobber), .commit_i(commit),
        .flu_ready_i(flu_ready), .lsu_ready_i(lsu_ready), .fu_data_o(fu_data),
        .alu_valid_o(alu_valid), .branch_valid_o(branch_valid), .lsu_valid_o(lsu_valid),
        .mult_valid_o(mult_valid), .csr_valid_o(csr_valid)
    );

    always #(clk_period / 2) clk_i = ~clk_i;

    // -------------------------------------------------------------------
    // helpers
    // -------------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // one-hot order alu, branch, lsu, mult, csr
    function automatic logic [4:0] strobe_for_unit(input fu_t fu);
        case (fu)
            fu_alu:            return 5'b10000;
            fu_ctrl_flow:      return 5'b01000;
            fu_load, fu_store: return 5'b00100;
            fu_mult:           return 5'b00010;
            fu_csr:            return 5'b00001;
            default:           return 5'b00000;
        endcase
    endfunction

    task automatic clear_sideband();
        for (int r = 0; r < nr_regs; r++) begin
            rd_clobber[r] = fu_none;
        end
        rs1_valid = 1'b0;
        rs2_valid = 1'b0;
        flu_ready = 1'b1;
        lsu_ready = 1'b1;
        flush_i   = 1'b0;
    endtask

    task automatic make_entry(input fu_t fu, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [4:0] rd, output issue_entry_t e);
        e          = '0;
        e.fu       = fu;
        // opaque to the stage, any code must come through
        e.op       = fu_op_t'(4'($random(seed)));
        e.rs1      = rs1;
        e.rs2      = rs2;
        e.rd       = rd;
        e.result   = $random(seed);
        e.pc       = $random(seed);
        e.trans_id = 3'(rd);
    endtask

    // both ports write on one edge, port 1 applied last, x0 never written
    task automatic commit_pair(input logic [4:0] a0, input logic [31:0] d0,
                               input logic [4:0] a1, input logic [31:0] d1);
        commit[0] = '{waddr: a0, wdata: d0, we: 1'b1};
        commit[1] = '{waddr: a1, wdata: d1, we: 1'b1};
        @(posedge clk_i);
        #1;
        commit[0].we = 1'b0;
        commit[1].we = 1'b0;
        if (a0 != 0) begin
            model[a0] = d0;
        end
        if (a1 != 0) begin
            model[a1] = d1;
        end
    endtask

    // present an entry for one cycle, check ack mid cycle, strobes after the edge
    task automatic try_issue(input string what, input issue_entry_t e, input logic exp_ack);
        logic [4:0] exp_strobes;
        issue_instr = e;
        issue_valid = 1'b1;
        #2;
        check_value({what, " ack"}, 32'(exp_ack), 32'(issue_ack));
        check_value({what, " rs1 echo"}, 32'(e.rs1), 32'(rs1_o));
        check_value({what, " rs2 echo"}, 32'(e.rs2), 32'(rs2_o));
        exp_strobes = (exp_ack && !e.ex_valid && !flush_i) ? strobe_for_unit(e.fu) : 5'b0;
        @(posedge clk_i);
        #1;
        issue_valid = 1'b0;
        check_value({what, " strobes"}, 32'(exp_strobes), 32'(strobes));
        check_value({what, " fu"}, 32'(e.fu), 32'(fu_data.fu));
        check_value({what, " op"}, 32'(e.op), 32'(fu_data.op));
        check_value({what, " trans_id"}, 32'(e.trans_id), 32'(fu_data.trans_id));
    endtask

    // -------------------------------------------------------------------
    // tests
    // -------------------------------------------------------------------
    task automatic regfile_and_alu_issue();
        issue_entry_t e;
        logic [31:0] shared_d1;
        test_name = "regfile_alu";
        commit_pair(5, $random(seed), 6, $random(seed));
        commit_pair(0, $random(seed), 7, $random(seed));
        shared_d1 = $random(seed);
        commit_pair(9, $random(seed), 9, shared_d1);
        make_entry(fu_alu, 5, 6, 1, e);
        try_issue("alu x5 x6", e, 1'b1);
        check_value("operand_a", model[5], fu_data.operand_a);
        check_value("operand_b", model[6], fu_data.operand_b);
        make_entry(fu_alu, 0, 9, 1, e);
        try_issue("alu x0 x9", e, 1'b1);
        check_value("x0 read", 32'h0, fu_data.operand_a);
        check_value("port 1 wins", shared_d1, fu_data.operand_b);
    endtask

    task automatic forwarding_and_stall();
        issue_entry_t e;
        test_name = "forward_stall";
        rd_clobber[5] = fu_alu;
        rs1_valid = 1'b1;
        rs1_i = $random(seed);
        make_entry(fu_alu, 5, 6, 2, e);
        try_issue("forward rs1", e, 1'b1);
        check_value("forwarded a", rs1_i, fu_data.operand_a);
        check_value("regfile b", model[6], fu_data.operand_b);
        // writer has not produced the value yet
        rs1_valid = 1'b0;
        try_issue("rs1 not ready", e, 1'b0);
        rd_clobber[5] = fu_none;
        rd_clobber[6] = fu_csr;
        rs2_valid = 1'b1;
        rs2_i = $random(seed);
        try_issue("rs2 from csr", e, 1'b0);
        clear_sideband();
    endtask

    task automatic operand_muxing();
        issue_entry_t e;
        test_name = "operand_select";
        make_entry(fu_alu, 5, 6, 2, e);
        e.use_pc = 1'b1;
        try_issue("use_pc", e, 1'b1);
        check_value("pc as a", e.pc, fu_data.operand_a);
        // zimm ignores a pending writer of rs1
        rd_clobber[5] = fu_alu;
        make_entry(fu_csr, 5, 6, 4, e);
        e.use_zimm = 1'b1;
        try_issue("use_zimm", e, 1'b1);
        check_value("zimm as a", {27'b0, e.rs1}, fu_data.operand_a);
        rd_clobber[5] = fu_none;
        make_entry(fu_alu, 5, 6, 2, e);
        e.use_imm = 1'b1;
        try_issue("alu use_imm", e, 1'b1);
        check_value("imm as b", e.result, fu_data.operand_b);
        make_entry(fu_store, 5, 6, 0, e);
        e.use_imm = 1'b1;
        try_issue("store use_imm", e, 1'b1);
        check_value("store b", model[6], fu_data.operand_b);
        check_value("store imm", e.result, fu_data.imm);
        // branches compare rs1 with rs2 and keep the offset in imm
        make_entry(fu_ctrl_flow, 5, 6, 0, e);
        e.use_imm = 1'b1;
        try_issue("branch use_imm", e, 1'b1);
        check_value("branch b", model[6], fu_data.operand_b);
        check_value("branch imm", e.result, fu_data.imm);
    endtask

    task automatic waw_and_readiness();
        issue_entry_t e;
        logic [31:0] d;
        test_name = "waw_ready";
        rd_clobber[3] = fu_load;
        make_entry(fu_alu, 5, 6, 3, e);
        try_issue("rd clobbered", e, 1'b0);
        // rd retires through port 0 in the issue cycle
        d = $random(seed);
        commit[0] = '{waddr: 5'd3, wdata: d, we: 1'b1};
        try_issue("rd committing", e, 1'b1);
        commit[0].we = 1'b0;
        model[3] = d;
        rd_clobber[3] = fu_none;
        flu_ready = 1'b0;
        try_issue("flu busy", e, 1'b0);
        // each unit group has its own ready
        flu_ready = 1'b1;
        lsu_ready = 1'b0;
        make_entry(fu_load, 5, 6, 7, e);
        try_issue("lsu busy", e, 1'b0);
        // rd pending and units busy, only the bypass grants these
        rd_clobber[7] = fu_alu;
        flu_ready = 1'b0;
        make_entry(fu_none, 5, 6, 7, e);
        try_issue("no unit", e, 1'b1);
        make_entry(fu_alu, 5, 6, 7, e);
        e.ex_valid = 1'b1;
        try_issue("exception", e, 1'b1);
        clear_sideband();
    endtask

    task automatic mult_rule_and_flush();
        issue_entry_t e;
        issue_entry_t e_mul;
        test_name = "mult_flush";
        make_entry(fu_mult, 5, 6, 1, e_mul);
        try_issue("first mult", e_mul, 1'b1);
        // mult strobe is high in this cycle
        make_entry(fu_mult, 5, 6, 2, e_mul);
        try_issue("mult behind mult", e_mul, 1'b1);
        // strobe held high by the second mult
        make_entry(fu_alu, 5, 6, 3, e);
        try_issue("alu behind mult", e, 1'b0);
        flush_i = 1'b1;
        try_issue("flushed alu", e, 1'b1);
        flush_i = 1'b0;
    endtask

    // -------------------------------------------------------------------
    // main sequence and watchdog
    // -------------------------------------------------------------------
    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        issue_instr = '0;
        issue_valid = 1'b0;
        rs1_i       = '0;
        rs2_i       = '0;
        commit      = '0;
        clear_sideband();
        for (int r = 0; r < nr_regs; r++) begin
            model[r] = '0;
        end
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        regfile_and_alu_issue();
        forwarding_and_stall();
        operand_muxing();
        waw_and_readiness();
        mult_rule_and_flush();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // budget covers reset plus every test at its worst length
    initial begin
        #((nr_tests * cycles_per_test + 10) * clk_period);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule
